// File: rtl/arcade_pkg.sv
// Shared types and constants of the arcade cabinet front end.
// Holds the host status word layout, the player and button words,
// the keyboard event and the input frame handed to the game core.
// Modules refer to these by scoped names.

package arcade_pkg;

	// ============================================================
	// Host status word
	// ============================================================

	// Option fields, listed from bit 31 down to bit 0
	typedef struct packed {
		logic [21:0] unused;
		logic        stop_junct;
		logic [1:0]  lives_sel;
		logic        energy;
		logic        blend;
		logic [1:0]  scanlines;
		logic        rotate;
		logic        reserved;
		logic        reset_req;
	} status_opt_t;

	// Same 32 bits, seen as the raw host word or as option fields
	typedef union packed {
		logic [31:0] raw;
		status_opt_t opt;
	} status_word_u;

	// ============================================================
	// Controls
	// ============================================================

	// Bit 0 is right, matching the joystick byte
	typedef struct packed {
		logic [5:0] fire;
		logic       up;
		logic       down;
		logic       left;
		logic       right;
	} player_ctl_t;

	typedef struct packed {
		logic       pressed;
		logic [7:0] code;
	} key_event_t;

	typedef struct packed {
		logic coin;
		logic start1;
		logic start2;
	} cabinet_btn_t;

	// One snapshot of all game inputs
	typedef struct packed {
		player_ctl_t [1:0] players;
		cabinet_btn_t      buttons;
		logic [7:0]        dip_1;
		logic [7:0]        dip_2;
	} input_frame_t;

	// PS/2 set 2 scan codes
	localparam logic [7:0] KEY_UP       = 8'h75;
	localparam logic [7:0] KEY_DOWN     = 8'h72;
	localparam logic [7:0] KEY_LEFT     = 8'h6B;
	localparam logic [7:0] KEY_RIGHT    = 8'h74;
	localparam logic [7:0] KEY_FIRE1    = 8'h29;
	localparam logic [7:0] KEY_P2_UP    = 8'h2D;
	localparam logic [7:0] KEY_P2_DOWN  = 8'h2B;
	localparam logic [7:0] KEY_P2_LEFT  = 8'h23;
	localparam logic [7:0] KEY_P2_RIGHT = 8'h34;
	localparam logic [7:0] KEY_P2_FIRE1 = 8'h1C;
	localparam logic [7:0] KEY_COIN     = 8'h2E;
	localparam logic [7:0] KEY_START1   = 8'h16;
	localparam logic [7:0] KEY_START2   = 8'h1E;

endpackage

// File: rtl/key_decoder.sv
// Keyboard event decoder for the cabinet front end.
// Accepts one key event per valid/ready transfer and keeps the
// held state of every mapped key. Player keys drive one control
// word per player, cabinet keys drive the coin and start buttons.
// Codes that map to nothing are accepted and dropped.

`timescale 1ns/1ps

module key_decoder #(
	parameter int NUM_PLAYERS = 2
) (
	input  logic                      clock_12,
	input  logic                      arst_n,
	input  arcade_pkg::key_event_t    key_event,
	input  logic                      key_valid,
	output logic                      key_ready,
	output arcade_pkg::player_ctl_t   kbd_ctl [NUM_PLAYERS],
	output arcade_pkg::cabinet_btn_t  kbd_btn
);

	// Per player code tables, index 0 is player 1
	localparam logic [7:0] UP_CODE [2]    = '{arcade_pkg::KEY_UP,    arcade_pkg::KEY_P2_UP};
	localparam logic [7:0] DOWN_CODE [2]  = '{arcade_pkg::KEY_DOWN,  arcade_pkg::KEY_P2_DOWN};
	localparam logic [7:0] LEFT_CODE [2]  = '{arcade_pkg::KEY_LEFT,  arcade_pkg::KEY_P2_LEFT};
	localparam logic [7:0] RIGHT_CODE [2] = '{arcade_pkg::KEY_RIGHT, arcade_pkg::KEY_P2_RIGHT};
	localparam logic [7:0] FIRE_CODE [2]  = '{arcade_pkg::KEY_FIRE1, arcade_pkg::KEY_P2_FIRE1};

	logic accept;

	assign accept = key_valid & key_ready;

	// Ready comes up once reset is gone and never drops
	always_ff @(posedge clock_12 or negedge arst_n) begin
		if (!arst_n) begin
			key_ready <= 1'b0;
		end else begin
			key_ready <= 1'b1;
		end
	end

	// ============================================================
	// Held key state
	// ============================================================

	always_ff @(posedge clock_12 or negedge arst_n) begin
		if (!arst_n) begin
			for (int p = 0; p < NUM_PLAYERS; p++) begin
				kbd_ctl[p] <= '0;
			end
			kbd_btn <= '0;
		end else if (accept) begin
			for (int p = 0; p < NUM_PLAYERS; p++) begin
				if (key_event.code == UP_CODE[p])
					kbd_ctl[p].up <= key_event.pressed;
				if (key_event.code == DOWN_CODE[p])
					kbd_ctl[p].down <= key_event.pressed;
				if (key_event.code == LEFT_CODE[p])
					kbd_ctl[p].left <= key_event.pressed;
				if (key_event.code == RIGHT_CODE[p])
					kbd_ctl[p].right <= key_event.pressed;
				// Only the first fire button has a key
				if (key_event.code == FIRE_CODE[p])
					kbd_ctl[p].fire[0] <= key_event.pressed;
			end

			case (key_event.code)
				arcade_pkg::KEY_COIN:   kbd_btn.coin   <= key_event.pressed;
				arcade_pkg::KEY_START1: kbd_btn.start1 <= key_event.pressed;
				arcade_pkg::KEY_START2: kbd_btn.start2 <= key_event.pressed;
				default: ;
			endcase
		end
	end

endmodule

// File: rtl/player_lane.sv
// One player's control lane.
// ORs the joystick byte with the keyboard word, turns the
// directions a quarter turn when the cabinet is rotated and
// registers the result. The top level places one lane per player.

`timescale 1ns/1ps

module player_lane (
	input  logic                     clock_12,
	input  logic                     arst_n,
	input  logic                     rotate,
	input  logic [7:0]               joystick,
	input  arcade_pkg::player_ctl_t  kbd_ctl,
	output arcade_pkg::player_ctl_t  ctl
);

	arcade_pkg::player_ctl_t merged;
	arcade_pkg::player_ctl_t turned;

	// Joystick has only four fire bits, the top two stay keyboard only
	assign merged = kbd_ctl | arcade_pkg::player_ctl_t'({2'b00, joystick});

	// Rotated cabinet maps right to up, up to left, left to down,
	// down to right
	always_comb begin
		turned = merged;
		if (rotate) begin
			turned.up    = merged.right;
			turned.left  = merged.up;
			turned.down  = merged.left;
			turned.right = merged.down;
		end
	end

	always_ff @(posedge clock_12 or negedge arst_n) begin
		if (!arst_n) begin
			ctl <= '0;
		end else begin
			ctl <= turned;
		end
	end

endmodule

// File: rtl/control_collector.sv
// Input frame collector for the game core.
// Gathers the lane words, the sticky coin and start presses and the
// dip switch bytes into one frame. A new snapshot loads when the
// current frame is taken, so a stalled frame stays unchanged.
// Valid rises one cycle after reset and stays high.

`timescale 1ns/1ps

module control_collector #(
	parameter int NUM_PLAYERS = 2
) (
	input  logic                      clock_12,
	input  logic                      arst_n,
	input  arcade_pkg::player_ctl_t   lane_ctl [NUM_PLAYERS],
	input  arcade_pkg::cabinet_btn_t  kbd_btn,
	input  arcade_pkg::status_word_u  status,
	output arcade_pkg::input_frame_t  frame,
	output logic                      frame_valid,
	input  logic                      frame_ready
);

	arcade_pkg::cabinet_btn_t held;
	arcade_pkg::cabinet_btn_t pending;
	arcade_pkg::input_frame_t next_frame;
	logic                     load;

	// First load right after reset, then one per transfer
	assign load    = ~frame_valid | frame_ready;
	assign pending = held | kbd_btn;

	// ============================================================
	// Snapshot contents
	// ============================================================

	always_comb begin
		next_frame = '0;
		for (int p = 0; p < NUM_PLAYERS; p++) begin
			next_frame.players[p] = lane_ctl[p];
		end
		next_frame.buttons = pending;
		// Cabinet bits, lives, energy, three unknown bits
		next_frame.dip_1 = {2'b11, ~status.opt.lives_sel, status.opt.energy, 3'b000};
		// Stop at junctions then cheat and coinage defaults
		next_frame.dip_2 = {~status.opt.stop_junct, 7'b110_1111};
	end

	always_ff @(posedge clock_12 or negedge arst_n) begin
		if (!arst_n) begin
			frame_valid <= 1'b0;
			held        <= '0;
		end else begin
			frame_valid <= 1'b1;
			if (load) begin
				// A button still down stays held for the frame after
				held <= kbd_btn;
			end else begin
				held <= pending;
			end
		end
	end

	always_ff @(posedge clock_12) begin
		if (load) begin
			frame <= next_frame;
		end
	end

endmodule

// File: rtl/reset_sequencer.sv
// Core reset generation.
// Holds the game core in reset until the ROM download has ended,
// then follows the host reset bit and the reset button. The output
// is registered and comes out of reset high.

`timescale 1ns/1ps

module reset_sequencer (
	input  logic                      clock_12,
	input  logic                      arst_n,
	input  logic                      rom_download,
	input  logic                      reset_button,
	input  arcade_pkg::status_word_u  status,
	output logic                      core_reset
);

	logic rom_download_q;
	logic rom_loaded;

	// Falling edge of the download flag marks a complete ROM
	always_ff @(posedge clock_12 or negedge arst_n) begin
		if (!arst_n) begin
			rom_download_q <= 1'b0;
			rom_loaded     <= 1'b0;
		end else begin
			rom_download_q <= rom_download;
			if (rom_download_q && !rom_download) begin
				rom_loaded <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock_12 or negedge arst_n) begin
		if (!arst_n) begin
			core_reset <= 1'b1;
		end else begin
			core_reset <= status.opt.reset_req | reset_button | ~rom_loaded;
		end
	end

endmodule

// File: rtl/sigma_delta_dac.sv
// First-order sigma-delta audio DAC.
// Adds the sample to an accumulator every clock; the carry out
// is the one-bit output, whose density follows the sample.
// Feed the pin through an RC low-pass filter.

`timescale 1ns/1ps

module sigma_delta_dac #(
	parameter int DAC_BITS = 11
) (
	input  logic                clock_12,
	input  logic                arst_n,
	input  logic [DAC_BITS-1:0] sample,
	output logic                audio_bit
);

	// Top bit holds the carry of the last addition
	logic [DAC_BITS:0] acc;

	always_ff @(posedge clock_12 or negedge arst_n) begin
		if (!arst_n) begin
			acc <= '0;
		end else begin
			acc <= {1'b0, acc[DAC_BITS-1:0]} + {1'b0, sample};
		end
	end

	assign audio_bit = acc[DAC_BITS];

endmodule

// File: rtl/arcade_frontend.sv
// Cabinet front end of the arcade core.
// Decodes the host status word, sequences the core reset, merges
// keyboard and joysticks into player controls, hands input frames
// to the game core and drives the audio pin.
// All logic runs on clock_12.

`timescale 1ns/1ps

module arcade_frontend #(
	parameter int NUM_PLAYERS = 2,
	parameter int DAC_BITS    = 11
) (
	input  logic                      clock_12,
	input  logic                      arst_n,
	input  logic [31:0]               status_raw,
	input  logic                      reset_button,
	input  logic                      rom_download,
	input  arcade_pkg::key_event_t    key_event,
	input  logic                      key_valid,
	output logic                      key_ready,
	input  logic [7:0]                joystick_0,
	input  logic [7:0]                joystick_1,
	output arcade_pkg::input_frame_t  frame,
	output logic                      frame_valid,
	input  logic                      frame_ready,
	output logic                      core_reset,
	input  logic [DAC_BITS-1:0]       audio_sample,
	output logic                      audio_bit
);

	arcade_pkg::status_word_u  status;
	arcade_pkg::player_ctl_t   kbd_ctl [NUM_PLAYERS];
	arcade_pkg::player_ctl_t   lane_ctl [NUM_PLAYERS];
	arcade_pkg::cabinet_btn_t  kbd_btn;
	logic [7:0]                joystick [NUM_PLAYERS];

	assign status.raw  = status_raw;
	assign joystick[0] = joystick_0;
	assign joystick[1] = joystick_1;

	reset_sequencer u_reset_sequencer (
		.clock_12     (clock_12),
		.arst_n       (arst_n),
		.rom_download (rom_download),
		.reset_button (reset_button),
		.status       (status),
		.core_reset   (core_reset)
	);

	// ============================================================
	// Controls
	// ============================================================

	key_decoder #(
		.NUM_PLAYERS (NUM_PLAYERS)
	) u_key_decoder (
		.clock_12  (clock_12),
		.arst_n    (arst_n),
		.key_event (key_event),
		.key_valid (key_valid),
		.key_ready (key_ready),
		.kbd_ctl   (kbd_ctl),
		.kbd_btn   (kbd_btn)
	);

	for (genvar p = 0; p < NUM_PLAYERS; p++) begin : g_lane
		player_lane u_player_lane (
			.clock_12 (clock_12),
			.arst_n   (arst_n),
			.rotate   (status.opt.rotate),
			.joystick (joystick[p]),
			.kbd_ctl  (kbd_ctl[p]),
			.ctl      (lane_ctl[p])
		);
	end

	control_collector #(
		.NUM_PLAYERS (NUM_PLAYERS)
	) u_control_collector (
		.clock_12    (clock_12),
		.arst_n      (arst_n),
		.lane_ctl    (lane_ctl),
		.kbd_btn     (kbd_btn),
		.status      (status),
		.frame       (frame),
		.frame_valid (frame_valid),
		.frame_ready (frame_ready)
	);

	// Audio
	sigma_delta_dac #(
		.DAC_BITS (DAC_BITS)
	) u_sigma_delta_dac (
		.clock_12  (clock_12),
		.arst_n    (arst_n),
		.sample    (audio_sample),
		.audio_bit (audio_bit)
	);

endmodule

// File: tests/tb_arcade_frontend.sv
// Testbench for the arcade cabinet front end.
// Drives random key events, joystick bytes, status words and frame
// back-pressure from a fixed seed. Every cycle the outputs are
// compared with a reference model of the held keys, lanes, frames
// and core reset. A pulse count of the audio DAC runs last.

`timescale 1ns/1ps

module tb_arcade_frontend;

	localparam int DAC_BITS       = 11;
	localparam int DAC_CYCLES     = 1 << DAC_BITS;
	localparam int DAC_SAMPLES    = 4;
	localparam int RESET_CYCLES   = 4;
	localparam int PHASE_CYCLES   = 400;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + 5 * PHASE_CYCLES
		+ DAC_SAMPLES * (DAC_CYCLES + 3) + 200;

	localparam logic [7:0] KEY_CODES [13] = '{
		arcade_pkg::KEY_UP, arcade_pkg::KEY_DOWN, arcade_pkg::KEY_LEFT,
		arcade_pkg::KEY_RIGHT, arcade_pkg::KEY_FIRE1, arcade_pkg::KEY_P2_UP,
		arcade_pkg::KEY_P2_DOWN, arcade_pkg::KEY_P2_LEFT, arcade_pkg::KEY_P2_RIGHT,
		arcade_pkg::KEY_P2_FIRE1, arcade_pkg::KEY_COIN, arcade_pkg::KEY_START1,
		arcade_pkg::KEY_START2};

	logic                     clock_12 = 1'b0;
	logic                     arst_n;
	logic [31:0]              status_raw;
	logic                     reset_button;
	logic                     rom_download;
	arcade_pkg::key_event_t   key_event;
	logic                     key_valid;
	logic                     key_ready;
	logic [7:0]               joystick_0;
	logic [7:0]               joystick_1;
	arcade_pkg::input_frame_t frame;
	logic                     frame_valid;
	logic                     frame_ready;
	logic                     core_reset;
	logic [DAC_BITS-1:0]      audio_sample;
	logic                     audio_bit;

	int seed        = 79;
	int cycle_count = 0;

	// Reference model state
	arcade_pkg::player_ctl_t  m_kbd [2];
	arcade_pkg::player_ctl_t  m_lane [2];
	arcade_pkg::cabinet_btn_t m_btn;
	arcade_pkg::cabinet_btn_t m_sticky;
	arcade_pkg::input_frame_t m_frame;
	arcade_pkg::input_frame_t prev_frame;
	logic                     m_valid;
	logic                     m_key_ready;
	logic                     m_dl_q;
	logic                     m_loaded;
	logic                     m_core_reset;
	logic                     hold_prev;

	arcade_frontend #(
		.NUM_PLAYERS (2),
		.DAC_BITS    (DAC_BITS)
	) u_dut (.*);

	always #10 clock_12 = ~clock_12;

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("TEST RESULT: FAIL");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	function automatic logic [31:0] rand_word();
		rand_word = $random(seed);
	endfunction

	// Quarter turn of a rotated cabinet with the fire bits untouched
	function automatic arcade_pkg::player_ctl_t turn(input arcade_pkg::player_ctl_t in,
		input logic rot);
		turn = in;
		if (rot) begin
			turn.up    = in.right;
			turn.left  = in.up;
			turn.down  = in.left;
			turn.right = in.down;
		end
	endfunction

	// ============================================================
	// Reference model
	// ============================================================

	task automatic reset_model();
		m_kbd[0]     = '0;
		m_kbd[1]     = '0;
		m_lane[0]    = '0;
		m_lane[1]    = '0;
		m_btn        = '0;
		m_sticky     = '0;
		m_valid      = 1'b0;
		m_key_ready  = 1'b0;
		m_dl_q       = 1'b0;
		m_loaded     = 1'b0;
		m_core_reset = 1'b1;
		hold_prev    = 1'b0;
	endtask

	task automatic compare_outputs();
		check_value("key_ready", 64'(key_ready), 64'(m_key_ready));
		check_value("core_reset", 64'(core_reset), 64'(m_core_reset));
		check_value("frame_valid", 64'(frame_valid), 64'(m_valid));
		if (m_valid) begin
			check_value("frame.players", 64'(frame.players), 64'(m_frame.players));
			check_value("frame.buttons", 64'(frame.buttons), 64'(m_frame.buttons));
			check_value("frame.dip_1", 64'(frame.dip_1), 64'(m_frame.dip_1));
			check_value("frame.dip_2", 64'(frame.dip_2), 64'(m_frame.dip_2));
		end
		// Stalled frame must not move
		if (hold_prev)
			check_value("frame under stall", 64'(frame), 64'(prev_frame));
		hold_prev  = frame_valid & ~frame_ready;
		prev_frame = frame;
	endtask

	// Next state from the inputs the DUT samples on the coming edge
	task automatic advance_model();
		logic [31:0] st;
		logic [7:0]  joy [2];
		logic        accept;
		st     = status_raw;
		joy[0] = joystick_0;
		joy[1] = joystick_1;
		accept = key_valid & m_key_ready;

		m_core_reset = st[0] | reset_button | ~m_loaded;
		if (m_dl_q && !rom_download)
			m_loaded = 1'b1;
		m_dl_q = rom_download;

		if (!m_valid || frame_ready) begin
			m_frame.players[0] = m_lane[0];
			m_frame.players[1] = m_lane[1];
			m_frame.buttons    = m_sticky | m_btn;
			// Lives sits at bits 8:7, energy at 6, stop_junct at 9
			m_frame.dip_1      = {2'b11, ~st[8:7], st[6], 3'b000};
			m_frame.dip_2      = {~st[9], 7'b1101111};
			m_sticky           = m_btn;
		end else begin
			m_sticky = m_sticky | m_btn;
		end
		m_valid = 1'b1;

		for (int p = 0; p < 2; p++)
			m_lane[p] = turn(m_kbd[p] | {2'b00, joy[p]}, st[2]);

		if (accept) begin
			case (key_event.code)
				arcade_pkg::KEY_UP:       m_kbd[0].up      = key_event.pressed;
				arcade_pkg::KEY_DOWN:     m_kbd[0].down    = key_event.pressed;
				arcade_pkg::KEY_LEFT:     m_kbd[0].left    = key_event.pressed;
				arcade_pkg::KEY_RIGHT:    m_kbd[0].right   = key_event.pressed;
				arcade_pkg::KEY_FIRE1:    m_kbd[0].fire[0] = key_event.pressed;
				arcade_pkg::KEY_P2_UP:    m_kbd[1].up      = key_event.pressed;
				arcade_pkg::KEY_P2_DOWN:  m_kbd[1].down    = key_event.pressed;
				arcade_pkg::KEY_P2_LEFT:  m_kbd[1].left    = key_event.pressed;
				arcade_pkg::KEY_P2_RIGHT: m_kbd[1].right   = key_event.pressed;
				arcade_pkg::KEY_P2_FIRE1: m_kbd[1].fire[0] = key_event.pressed;
				arcade_pkg::KEY_COIN:     m_btn.coin       = key_event.pressed;
				arcade_pkg::KEY_START1:   m_btn.start1     = key_event.pressed;
				arcade_pkg::KEY_START2:   m_btn.start2     = key_event.pressed;
				default: ;
			endcase
		end
		m_key_ready = 1'b1;
	endtask

	always @(negedge clock_12) begin
		if (!arst_n) begin
			reset_model();
		end else begin
			compare_outputs();
			advance_model();
		end
	end

	always @(posedge clock_12) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST RESULT: FAIL");
			$fatal(1, "Timeout");
		end
	end

	// ============================================================
	// Stimulus
	// ============================================================

	// rot_mode 0 keeps rotate off, 1 keeps it on, 2 randomizes it
	task automatic drive_cycle(input int rot_mode, input bit random_ready);
		logic [31:0] st;
		logic [31:0] r;
		int          pick;
		@(posedge clock_12);
		st = rand_word();
		r  = rand_word();
		st[0] = (r[3:0] == 4'd0);
		if (rot_mode < 2)
			st[2] = rot_mode[0];
		status_raw   <= st;
		reset_button <= (r[7:4] == 4'd0);
		joystick_0   <= r[15:8] & r[23:16];
		joystick_1   <= r[31:24] & st[31:24];
		r    = rand_word();
		pick = int'(r[3:0]);
		key_valid         <= r[4];
		key_event.pressed <= r[5];
		key_event.code    <= (pick < 13) ? KEY_CODES[pick] : r[15:8];
		// Ready mostly low gives long stalls
		frame_ready <= random_ready ? (r[17:16] == 2'd0) : 1'b1;
	endtask

	initial begin
		int                  ones;
		logic [31:0]         r;
		logic [DAC_BITS-1:0] sample;
		arst_n       = 1'b0;
		status_raw   = '0;
		reset_button = 1'b0;
		rom_download = 1'b1;
		key_event    = '0;
		key_valid    = 1'b0;
		joystick_0   = '0;
		joystick_1   = '0;
		frame_ready  = 1'b1;
		audio_sample = '0;
		repeat (RESET_CYCLES) @(posedge clock_12);
		arst_n <= 1'b1;

		// Download running and then finished
		repeat (PHASE_CYCLES / 2) drive_cycle(0, 1'b0);
		rom_download <= 1'b0;
		repeat (PHASE_CYCLES / 2) drive_cycle(0, 1'b0);
		repeat (PHASE_CYCLES) drive_cycle(0, 1'b0);
		repeat (PHASE_CYCLES) drive_cycle(1, 1'b0);
		// Back-pressure with random rotation and options
		repeat (2 * PHASE_CYCLES) drive_cycle(2, 1'b1);

		@(posedge clock_12);
		key_valid   <= 1'b0;
		frame_ready <= 1'b1;
		for (int i = 0; i < DAC_SAMPLES; i++) begin
			r      = rand_word();
			sample = r[DAC_BITS-1:0];
			audio_sample <= sample;
			repeat (2) @(posedge clock_12);
			ones = 0;
			repeat (DAC_CYCLES) begin
				@(negedge clock_12);
				if (audio_bit)
					ones++;
			end
			// Density within one count of the sample
			if (ones >= int'(sample) - 1 && ones <= int'(sample) + 1)
				ones = int'(sample);
			check_value("audio_bit ones", 64'(ones), 64'(sample));
			@(posedge clock_12);
		end

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// File: src.f
rtl/arcade_pkg.sv
rtl/key_decoder.sv
rtl/player_lane.sv
rtl/control_collector.sv
rtl/reset_sequencer.sv
rtl/sigma_delta_dac.sv
rtl/arcade_frontend.sv
tests/tb_arcade_frontend.sv

// File: run.sh
#!/bin/sh
# Build the front end testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_arcade_frontend -f src.f \
	-Mdir obj_dir -o tb_arcade_frontend

./obj_dir/tb_arcade_frontend > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
